//--- vlog.f
logic/icache_pkg.sv
logic/icache_beat_counter.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_mem_port.sv
logic/icache_hit_fsm.sv
logic/icache_top.sv
verification/icache_checker.sv
verification/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  - logic/icache_pkg.sv
  - logic/icache_beat_counter.sv
  - logic/icache_tag_array.sv
  - logic/icache_data_array.sv
  - logic/icache_mem_port.sv
  - logic/icache_hit_fsm.sv
  - logic/icache_top.sv
  - target: test
    files:
      - verification/icache_checker.sv
      - verification/icache_tb.sv

//--- verification/icache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tb
  import icache_pkg::*;
;

  localparam int          CYC_PER_OP = 200;
  localparam int          N_RAND     = 32;
  localparam int          N_DELAY    = 64;
  localparam logic [31:0] SEED       = 32'h63523063;

  // one stimulus row
  typedef struct packed {
    logic             is_flush;
    logic [ADR_W-1:0] adr;
    logic [2:0]       mem_xfers;
    logic             err;
  } op_t;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              fetch_req;
  icache_fetch_req_t fetch;
  logic              fetch_ack;
  icache_fetch_rsp_t fetch_rsp;
  logic              flush_req;
  logic              flush_ack;
  logic              mem_req;
  icache_mem_req_t   mem_cmd;
  logic              mem_ack;
  icache_mem_rsp_t   mem_rsp;

  op_t         ops [$];
  int unsigned mem_delay [N_DELAY];
  int          mem_cnt;
  int          cyc_cnt;
  int          cyc_limit;
  int          error_cnt;

  always #4 clk = ~clk;

  icache_top icache_top_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .fetch_req_i (fetch_req),
    .fetch_i     (fetch),
    .fetch_ack_o (fetch_ack),
    .fetch_rsp_o (fetch_rsp),
    .flush_req_i (flush_req),
    .flush_ack_o (flush_ack),
    .mem_req_o   (mem_req),
    .mem_o       (mem_cmd),
    .mem_ack_i   (mem_ack),
    .mem_i       (mem_rsp)
  );

  bind icache_top icache_checker checker_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fetch_req_i (fetch_req_i),
    .fetch_ack_i (fetch_ack_o),
    .flush_ack_i (flush_ack_o),
    .mem_req_i   (mem_req_o),
    .mem_ack_i   (mem_ack_i),
    .state_i     (state)
  );

  ////////////////////////////////////////
  // memory rule
  ////////////////////////////////////////
  function automatic logic [DATA_W-1:0] mem_word(input logic [ADR_W-1:0] adr);
    return {adr[ADR_W-1:2], 2'b00} ^ 32'hC0DE_0000;
  endfunction

  // error region in bits 15:12
  function automatic logic mem_err(input logic [ADR_W-1:0] adr);
    return adr[15:12] == 4'hE;
  endfunction

  task automatic report_error(input string msg);
    error_cnt++;
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_rsp(input icache_fetch_rsp_t got, input icache_fetch_rsp_t exp,
                           input logic [ADR_W-1:0] adr);
    // rdata is a don't-care on a bus error
    if (got.err !== exp.err || (!exp.err && got.rdata !== exp.rdata))
      report_error($sformatf("[FAIL] %0t ns: fetch %08h got rdata %08h err %0b, exp %08h err %0b",
                             $time, adr, got.rdata, got.err, exp.rdata, exp.err));
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
      report_error($sformatf("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////
  initial
  begin : memory_model
    logic [ADR_W-1:0] adr;
    mem_ack = 1'b0;
    mem_rsp = '0;
    mem_cnt = 0;
    forever
    begin
      @(negedge clk);
      if (mem_req && !mem_ack)
      begin
        adr = mem_cmd.adr;
        repeat (mem_delay[mem_cnt % N_DELAY]) @(posedge clk);
        @(posedge clk);
        mem_ack       <= 1'b1;
        mem_rsp.rdata <= mem_word(adr);
        mem_rsp.err   <= mem_err(adr);
        mem_cnt++;
        // hold ack until req released
        @(negedge clk);
        while (mem_req)
          @(negedge clk);
        @(posedge clk);
        mem_ack <= 1'b0;
      end
    end
  end

  // watchdog and bound checker status
  always @(posedge clk)
  begin
    cyc_cnt <= cyc_cnt + 1;
    if (icache_top_i.checker_i.fail_cnt != 0)
      report_error("a handshake assertion in the bound checker failed");
    else if (cyc_limit > 0 && cyc_cnt >= cyc_limit)
      report_error($sformatf("timeout: run still busy after %0d cycles", cyc_cnt));
  end

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////
  task automatic add_fetch(input logic [ADR_W-1:0] adr, input int xfers, input logic err);
    ops.push_back('{is_flush: 1'b0, adr: adr, mem_xfers: 3'(xfers), err: err});
  endtask

  task automatic add_flush();
    ops.push_back('{is_flush: 1'b1, adr: '0, mem_xfers: 3'd0, err: 1'b0});
  endtask

  task automatic build_table();
    // cold line, then hits at every word
    add_fetch(32'h0000_1048, 4, 1'b0);
    add_fetch(32'h0000_1040, 0, 1'b0);
    add_fetch(32'h0000_104C, 0, 1'b0);
    add_fetch(32'h0000_1044, 0, 1'b0);
    add_fetch(32'h0002_3100, 4, 1'b0);
    add_fetch(32'h0002_3102, 0, 1'b0);
    // same index, other tag evicts
    add_fetch(32'h0005_1040, 4, 1'b0);
    add_fetch(32'h0000_1040, 4, 1'b0);
    // uncached never allocates
    add_fetch(32'h8000_2010, 1, 1'b0);
    add_fetch(32'h8000_2010, 1, 1'b0);
    add_fetch(32'h8000_2014, 1, 1'b0);
    // flush drops all lines
    add_flush();
    add_fetch(32'h0002_3104, 4, 1'b0);
    add_fetch(32'h0002_3108, 0, 1'b0);
    add_fetch(32'h0000_104C, 4, 1'b0);
    // error line stays invalid
    add_fetch(32'h0000_E020, 1, 1'b1);
    add_fetch(32'h0000_E024, 1, 1'b1);
    add_fetch(32'h8000_E000, 1, 1'b1);
    add_fetch(32'h0002_3100, 0, 1'b0);
  endtask

  // random mix, expected counts from a local hit model
  task automatic add_random_run(input int n);
    icache_adr_u      a;
    int               exp_xfers;
    logic [LINES-1:0] mdl_valid;
    logic [TAG_W-2:0] mdl_tag [LINES];
    add_flush();
    mdl_valid = '0;
    for (int i = 0; i < n; i++)
    begin
      a.w          = '0;
      a.f.uncached = ($urandom_range(3, 0) == 0);
      case ($urandom_range(2, 0))
        0:       a.f.tag_rem = 23'h000010;
        1:       a.f.tag_rem = 23'h000023;
        default: a.f.tag_rem = 23'h004201;
      endcase
      // few indexes for hits and evictions
      a.f.idx  = IDX_W'($urandom_range(3, 0));
      a.f.offs = OFFS_W'($urandom_range(3, 0));
      if (a.f.uncached)
      begin
        exp_xfers = 1;
      end
      else if (mdl_valid[a.f.idx] && mdl_tag[a.f.idx] == a.f.tag_rem)
      begin
        exp_xfers = 0;
      end
      else
      begin
        exp_xfers            = 4;
        mdl_valid[a.f.idx]   = 1'b1;
        mdl_tag[a.f.idx]     = a.f.tag_rem;
      end
      add_fetch(a.w, exp_xfers, 1'b0);
    end
  endtask

  ////////////////////////////////////////
  // handshake drivers
  ////////////////////////////////////////
  task automatic run_fetch(input op_t op);
    icache_fetch_rsp_t got;
    icache_fetch_rsp_t exp;
    int                lat;
    int                mem_before;
    mem_before = mem_cnt;
    @(posedge clk);
    fetch_req   <= 1'b1;
    fetch.adr.w <= op.adr;
    @(negedge clk);
    lat = 0;
    while (!fetch_ack)
    begin
      @(negedge clk);
      lat++;
    end
    got       = fetch_rsp;
    exp.rdata = mem_word(op.adr);
    exp.err   = op.err;
    check_rsp(got, exp, op.adr);
    check_count(mem_cnt - mem_before, int'(op.mem_xfers), "memory transactions");
    if (op.mem_xfers == 0)
      check_count(lat, 1, "hit latency");
    // four-phase release
    @(posedge clk);
    fetch_req <= 1'b0;
    @(negedge clk);
    while (fetch_ack)
      @(negedge clk);
  endtask

  task automatic run_flush();
    int mem_before;
    mem_before = mem_cnt;
    @(posedge clk);
    flush_req <= 1'b1;
    @(negedge clk);
    while (!flush_ack)
      @(negedge clk);
    @(posedge clk);
    flush_req <= 1'b0;
    @(negedge clk);
    while (flush_ack)
      @(negedge clk);
    check_count(mem_cnt - mem_before, 0, "memory transactions during flush");
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial
  begin
    void'($urandom(SEED));
    rst_n     = 1'b0;
    fetch_req = 1'b0;
    fetch     = '0;
    flush_req = 1'b0;
    cyc_cnt   = 0;
    cyc_limit = 0;
    error_cnt = 0;
    foreach (mem_delay[i])
      mem_delay[i] = $urandom_range(3, 0);
    build_table();
    add_random_run(N_RAND);
    cyc_limit = ops.size() * CYC_PER_OP;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    foreach (ops[i])
    begin
      if (ops[i].is_flush)
        run_flush();
      else
        run_fetch(ops[i]);
    end
    repeat (2) @(posedge clk);
    if (error_cnt == 0 && icache_top_i.checker_i.fail_cnt == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/icache_checker.sv
`timescale 1ns/10ps
`default_nettype none

module icache_checker
  import icache_pkg::*;
(
  input wire logic          clk_i,
  input wire logic          rst_ni,
  input wire logic          fetch_req_i,
  input wire logic          fetch_ack_i,
  input wire logic          flush_ack_i,
  input wire logic          mem_req_i,
  input wire logic          mem_ack_i,
  input wire icache_state_e state_i
);

  // failed assertions so far
  int unsigned fail_cnt = 0;

  ////////////////////////////////////////
  // core handshake
  ////////////////////////////////////////
  // ack only answers a live request
  ack_rise_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(fetch_ack_i) |-> fetch_req_i)
    else
    begin
      $error("fetch ack rose without a fetch request");
      fail_cnt++;
    end

  // ack released only after the core let go
  ack_fall_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(fetch_ack_i) |-> $past(!fetch_req_i))
    else
    begin
      $error("fetch ack fell while the request was still high");
      fail_cnt++;
    end

  ////////////////////////////////////////
  // memory and flush
  ////////////////////////////////////////
  // req held until memory acks
  mem_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_i && !mem_ack_i) |=> mem_req_i)
    else
    begin
      $error("memory request dropped before ack");
      fail_cnt++;
    end

  // full sweep of 16 lines before ack
  flush_ack_after_sweep: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(flush_ack_i) |-> ($past(state_i, 1) == FLUSH) && ($past(state_i, 16) == FLUSH))
    else
    begin
      $error("flush ack rose before all lines were cleared");
      fail_cnt++;
    end

endmodule

`default_nettype wire

//--- logic/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_top
  import icache_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  // core fetch
  input  logic              fetch_req_i,
  input  icache_fetch_req_t fetch_i,
  output logic              fetch_ack_o,
  output icache_fetch_rsp_t fetch_rsp_o,
  // invalidate all
  input  logic              flush_req_i,
  output logic              flush_ack_o,
  // memory
  output logic              mem_req_o,
  output icache_mem_req_t   mem_o,
  input  logic              mem_ack_i,
  input  icache_mem_rsp_t   mem_i
);

  logic              hit;
  logic [DATA_W-1:0] rdata;
  logic [IDX_W-1:0]  cnt;
  logic              cnt_last;
  logic              cnt_clear;
  logic              cnt_step;
  logic              tag_we;
  logic              tag_inval;
  logic              data_we;
  logic              xfer_start;
  icache_mem_req_t   xfer_adr;
  logic              xfer_done;
  icache_mem_rsp_t   xfer_rsp;
  icache_state_e     state;

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////
  icache_hit_fsm hit_fsm_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fetch_req_i  (fetch_req_i),
    .fetch_i      (fetch_i),
    .fetch_ack_o  (fetch_ack_o),
    .fetch_rsp_o  (fetch_rsp_o),
    .flush_req_i  (flush_req_i),
    .flush_ack_o  (flush_ack_o),
    .hit_i        (hit),
    .rdata_i      (rdata),
    .cnt_i        (cnt),
    .cnt_last_i   (cnt_last),
    .cnt_clear_o  (cnt_clear),
    .cnt_step_o   (cnt_step),
    .tag_we_o     (tag_we),
    .tag_inval_o  (tag_inval),
    .data_we_o    (data_we),
    .xfer_start_o (xfer_start),
    .xfer_adr_o   (xfer_adr),
    .xfer_done_i  (xfer_done),
    .xfer_rsp_i   (xfer_rsp),
    .state_o      (state)
  );

  // fill beats and flush lines share one counter
  icache_beat_counter beat_counter_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (cnt_clear),
    .step_i  (cnt_step),
    .mode_i  (state),
    .count_o (cnt),
    .last_o  (cnt_last)
  );

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////
  icache_tag_array tag_array_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_adr_i    (fetch_i.adr),
    .we_i        (tag_we),
    .inval_i     (tag_inval),
    .inval_idx_i (cnt),
    .hit_o       (hit)
  );

  // fill offset from the low counter bits
  icache_data_array data_array_i (
    .clk_i     (clk_i),
    .adr_i     (fetch_i.adr),
    .we_i      (data_we),
    .wr_offs_i (cnt[OFFS_W-1:0]),
    .wdata_i   (xfer_rsp.rdata),
    .rdata_o   (rdata)
  );

  ////////////////////////////////////////
  // memory side
  ////////////////////////////////////////
  icache_mem_port mem_port_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (xfer_start),
    .adr_i     (xfer_adr),
    .done_o    (xfer_done),
    .rsp_o     (xfer_rsp),
    .mem_req_o (mem_req_o),
    .mem_o     (mem_o),
    .mem_ack_i (mem_ack_i),
    .mem_i     (mem_i)
  );

endmodule

`default_nettype wire

//--- logic/icache_hit_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module icache_hit_fsm
  import icache_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  // core side
  input  logic              fetch_req_i,
  input  icache_fetch_req_t fetch_i,
  output logic              fetch_ack_o,
  output icache_fetch_rsp_t fetch_rsp_o,
  input  logic              flush_req_i,
  output logic              flush_ack_o,
  // arrays
  input  logic              hit_i,
  input  logic [DATA_W-1:0] rdata_i,
  input  logic [IDX_W-1:0]  cnt_i,
  input  logic              cnt_last_i,
  output logic              cnt_clear_o,
  output logic              cnt_step_o,
  output logic              tag_we_o,
  output logic              tag_inval_o,
  output logic              data_we_o,
  // memory port
  output logic              xfer_start_o,
  output icache_mem_req_t   xfer_adr_o,
  input  logic              xfer_done_i,
  input  icache_mem_rsp_t   xfer_rsp_i,
  output icache_state_e     state_o
);

  icache_state_e     state_q;
  logic              flush_req_q;
  logic              flush_pend_q;
  logic              uncached;
  logic [OFFS_W-1:0] next_offs;
  icache_adr_u       beat_adr;

  assign uncached  = fetch_i.adr.f.uncached;
  assign next_offs = cnt_i[OFFS_W-1:0] + 1'b1;
  assign state_o   = state_q;

  ////////////////////////////////////////
  // flush handshake
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      flush_req_q  <= 1'b0;
      flush_pend_q <= 1'b0;
      flush_ack_o  <= 1'b0;
    end
    else
    begin
      flush_req_q <= flush_req_i;
      // latch on rising req, drop once FLUSH is entered
      if (flush_req_i && !flush_req_q)
        flush_pend_q <= 1'b1;
      else if (state_q == ARMED && flush_pend_q)
        flush_pend_q <= 1'b0;
      // ack after last line, release with req
      if (state_q == FLUSH && cnt_last_i)
        flush_ack_o <= 1'b1;
      else if (!flush_req_i)
        flush_ack_o <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // commands to counter, arrays, port
  ////////////////////////////////////////
  always_comb
  begin
    beat_adr             = fetch_i.adr;
    beat_adr.f.byte_offs = '0;
    xfer_start_o         = 1'b0;
    cnt_clear_o          = 1'b0;
    cnt_step_o           = 1'b0;
    tag_we_o             = 1'b0;
    tag_inval_o          = 1'b0;
    case (state_q)
      ARMED:
      begin
        if (flush_pend_q)
        begin
          cnt_clear_o = 1'b1;
        end
        else if (fetch_req_i && uncached)
        begin
          xfer_start_o = 1'b1;
        end
        else if (fetch_req_i && !hit_i)
        begin
          // first beat at word 0 of the line
          beat_adr.f.offs = '0;
          xfer_start_o    = 1'b1;
          cnt_clear_o     = 1'b1;
        end
      end
      FLUSH:
      begin
        // one line per cycle
        tag_inval_o = 1'b1;
        cnt_step_o  = 1'b1;
      end
      FILL:
      begin
        if (xfer_done_i && xfer_rsp_i.err)
        begin
          // claim line but keep it invalid
          tag_we_o    = 1'b1;
          tag_inval_o = 1'b1;
        end
        else if (xfer_done_i && cnt_last_i)
        begin
          tag_we_o = 1'b1;
        end
        else if (xfer_done_i)
        begin
          beat_adr.f.offs = next_offs;
          xfer_start_o    = 1'b1;
          cnt_step_o      = 1'b1;
        end
      end
      default:
      begin
      end
    endcase
  end

  assign xfer_adr_o.adr = beat_adr.w;
  // fill word lands at the current beat offset
  assign data_we_o      = (state_q == FILL) & xfer_done_i & ~xfer_rsp_i.err;

  ////////////////////////////////////////
  // state and core ack
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q     <= ARMED;
      fetch_ack_o <= 1'b0;
    end
    else
    begin
      case (state_q)
        ARMED:
        begin
          if (flush_pend_q)
          begin
            state_q <= FLUSH;
          end
          else if (fetch_req_i && uncached)
          begin
            state_q <= UNCACHED;
          end
          else if (fetch_req_i && hit_i)
          begin
            state_q     <= RESPOND;
            fetch_ack_o <= 1'b1;
          end
          else if (fetch_req_i)
          begin
            state_q <= FILL;
          end
        end
        FLUSH:
        begin
          if (cnt_last_i)
            state_q <= ARMED;
        end
        FILL:
        begin
          if (xfer_done_i && xfer_rsp_i.err)
          begin
            state_q     <= RESPOND;
            fetch_ack_o <= 1'b1;
          end
          else if (xfer_done_i && cnt_last_i)
          begin
            state_q <= RECOVER;
          end
        end
        // arrays settle, hit taken in ARMED
        RECOVER:
        begin
          state_q <= ARMED;
        end
        UNCACHED:
        begin
          if (xfer_done_i)
          begin
            state_q     <= RESPOND;
            fetch_ack_o <= 1'b1;
          end
        end
        RESPOND:
        begin
          if (!fetch_req_i)
          begin
            state_q     <= ARMED;
            fetch_ack_o <= 1'b0;
          end
        end
        default:
        begin
          state_q <= ARMED;
        end
      endcase
    end
  end

  // response word, stable while in RESPOND
  always_ff @(posedge clk_i)
  begin
    if (state_q == ARMED)
    begin
      fetch_rsp_o.rdata <= rdata_i;
      fetch_rsp_o.err   <= 1'b0;
    end
    else if (xfer_done_i)
    begin
      fetch_rsp_o.rdata <= xfer_rsp_i.rdata;
      fetch_rsp_o.err   <= xfer_rsp_i.err;
    end
  end

endmodule

`default_nettype wire

//--- logic/icache_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module icache_mem_port
  import icache_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            start_i,
  input  icache_mem_req_t adr_i,
  output logic            done_o,
  output icache_mem_rsp_t rsp_o,
  // memory side
  output logic            mem_req_o,
  output icache_mem_req_t mem_o,
  input  logic            mem_ack_i,
  input  icache_mem_rsp_t mem_i
);

  enum logic [1:0] {
    IDLE,
    REQ,
    DROP
  } state_q;

  ////////////////////////////////////////
  // four-phase requester
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q   <= IDLE;
      mem_req_o <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          if (start_i)
          begin
            state_q   <= REQ;
            mem_req_o <= 1'b1;
          end
        end
        // hold req until memory acks
        REQ:
        begin
          if (mem_ack_i)
          begin
            state_q   <= DROP;
            mem_req_o <= 1'b0;
          end
        end
        // wait for ack release, next fill beat may start in the done cycle
        DROP:
        begin
          if (!mem_ack_i)
          begin
            state_q   <= start_i ? REQ : IDLE;
            mem_req_o <= start_i;
          end
        end
        default:
        begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // address and response payloads
  always_ff @(posedge clk_i)
  begin
    if (start_i && (state_q == IDLE || done_o))
      mem_o <= adr_i;
    if (state_q == REQ && mem_ack_i)
      rsp_o <= mem_i;
  end

  // single cycle, transaction fully closed
  assign done_o = (state_q == DROP) & ~mem_ack_i;

endmodule

`default_nettype wire

//--- logic/icache_data_array.sv
`timescale 1ns/10ps
`default_nettype none

module icache_data_array
  import icache_pkg::*;
(
  input  logic              clk_i,
  input  icache_adr_u       adr_i,
  input  logic              we_i,
  input  logic [OFFS_W-1:0] wr_offs_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o
);

  localparam int DEPTH = LINES * WORDS_PER_LINE;

  logic [DATA_W-1:0]       mem_q [DEPTH];
  logic [IDX_W+OFFS_W-1:0] wr_ptr;
  logic [IDX_W+OFFS_W-1:0] rd_ptr;

  // line index on top, word in line below
  assign wr_ptr = {adr_i.f.idx, wr_offs_i};
  assign rd_ptr = {adr_i.f.idx, adr_i.f.offs};

  ////////////////////////////////////////
  // word-wise fill
  ////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (we_i)
      mem_q[wr_ptr] <= wdata_i;
  end

  // async word read
  assign rdata_o = mem_q[rd_ptr];

endmodule

`default_nettype wire

//--- logic/icache_tag_array.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tag_array
  import icache_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  icache_adr_u      rd_adr_i,
  input  logic             we_i,
  input  logic             inval_i,
  input  logic [IDX_W-1:0] inval_idx_i,
  output logic             hit_o
);

  logic [LINES-1:0] valid_q;
  logic [TAG_W-1:0] tag_q [LINES];
  logic [TAG_W-1:0] adr_tag;
  logic [IDX_W-1:0] idx;

  assign idx     = rd_adr_i.f.idx;
  // uncached flag is the tag msb
  assign adr_tag = {rd_adr_i.f.uncached, rd_adr_i.f.tag_rem};

  ////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
    end
    else if (we_i)
    begin
      // write with inval leaves the line invalid
      valid_q[idx] <= ~inval_i;
    end
    else if (inval_i)
    begin
      // flush path
      valid_q[inval_idx_i] <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // tag storage
  ////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (we_i)
      tag_q[idx] <= adr_tag;
  end

  // async lookup
  assign hit_o = valid_q[idx] & (tag_q[idx] == adr_tag);

endmodule

`default_nettype wire

//--- logic/icache_beat_counter.sv
`timescale 1ns/10ps
`default_nettype none

module icache_beat_counter
  import icache_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             step_i,
  // fsm state picks the end count
  input  icache_state_e    mode_i,
  output logic [IDX_W-1:0] count_o
  ,
  output logic             last_o
);

  ////////////////////////////////////////
  // beat / line counter
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      count_o <= '0;
    else if (clear_i)
      count_o <= '0;
    else if (step_i)
      count_o <= count_o + 1'b1;
  end

  // final fill beat or final flush line
  always_comb
  begin
    case (mode_i)
      FILL:
        last_o = (count_o == IDX_W'(WORDS_PER_LINE - 1));
      FLUSH:
        last_o = (count_o == IDX_W'(LINES - 1));
      default:
        last_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/icache_pkg.sv
`default_nettype none

package icache_pkg;

  ////////////////////////////////////////
  // geometry
  ////////////////////////////////////////
  localparam int ADR_W          = 32;
  localparam int DATA_W         = 32;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINES          = 16;
  localparam int BYTE_W         = 2;
  localparam int OFFS_W         = $clog2(WORDS_PER_LINE);
  localparam int IDX_W          = $clog2(LINES);
  // full tag includes the uncached flag
  localparam int TAG_W          = ADR_W - IDX_W - OFFS_W - BYTE_W;

  ////////////////////////////////////////
  // address views
  ////////////////////////////////////////
  typedef struct packed {
    logic              uncached;
    logic [TAG_W-2:0]  tag_rem;
    logic [IDX_W-1:0]  idx;
    logic [OFFS_W-1:0] offs;
    logic [BYTE_W-1:0] byte_offs;
  } icache_adr_fields_t;

  // flat word for memory, fields for the arrays
  typedef union packed {
    logic [ADR_W-1:0]   w;
    icache_adr_fields_t f;
  } icache_adr_u;

  ////////////////////////////////////////
  // port payloads
  ////////////////////////////////////////
  typedef struct packed {
    icache_adr_u adr;
  } icache_fetch_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } icache_fetch_rsp_t;

  // word aligned
  typedef struct packed {
    logic [ADR_W-1:0] adr;
  } icache_mem_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } icache_mem_rsp_t;

  typedef enum logic [2:0] {
    ARMED,
    FLUSH,
    FILL,
    RECOVER,
    UNCACHED,
    RESPOND
  } icache_state_e;

endpackage

`default_nettype wire
